/* build.f */
isa_pkg.sv
accuracy_pkg.sv
alu_decoder.sv
barrel_shifter.sv
carry_select_block.sv
approx_adder.sv
rv_alu.sv
rv_alu_assert.sv
tb_rv_alu.sv

/* run.sh */
#!/bin/sh
# Compile the rv_alu testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_rv_alu -o sim_rv_alu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_rv_alu)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* tb_rv_alu.sv */
// Testbench for the registered RV32I ALU with the accuracy-controllable adder.
// Drives OP and OP_IMM operations and predicts each result with a reference model.
// Results are checked in the low clock phase, one cycle after each issue.
`default_nettype none

module tb_rv_alu;

    localparam int XLEN    = 32;
    localparam int APX_LEN = 8;
    // Input drive delay after the rising edge
    localparam int drive_delay = 10;
    // Issues per test group
    localparam int n_logic  = 160;
    localparam int n_shift  = 120;
    localparam int n_add    = 120;
    localparam int n_approx = 160;
    localparam int n_bad    = 40;
    localparam int n_issues = n_logic + n_shift + n_add + n_approx + n_bad;
    // All issues, idle gaps of the logic group, reset and drain, plus margin
    localparam int max_cycles = n_issues + n_logic / 4 + 360;
    // Logic and compare funct3 codes, picked in turn
    localparam logic [2:0] logic_f3 [5] = '{isa_pkg::f3_slt, isa_pkg::f3_sltu,
                                            isa_pkg::f3_xor, isa_pkg::f3_or, isa_pkg::f3_and};

    logic                        clk;
    logic                        arst_n;
    logic                        issue;
    isa_pkg::instr_ctrl_t        ctrl;
    accuracy_pkg::accuracy_csr_t accuracy;
    logic [XLEN-1:0]             rs1;
    logic [XLEN-1:0]             rs2;
    logic [XLEN-1:0]             imm;
    logic [XLEN-1:0]             result;
    logic                        result_valid;

    integer          seed = 98191;
    int              cycles = 0;
    int              n_checked = 0;
    // Issue as sampled by the DUT at the last rising edge
    logic            issue_seen;
    // Expected results of operations in flight, oldest first
    logic [XLEN-1:0] expected_q[$];

    rv_alu #(
        .XLEN    (XLEN),
        .APX_LEN (APX_LEN)
    ) rv_alu_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue        (issue),
        .ctrl         (ctrl),
        .accuracy     (accuracy),
        .rs1          (rs1),
        .rs2          (rs2),
        .imm          (imm),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    // Error-configurable full adder, returns {carry, sum}
    function automatic logic [1:0] config_full_add(input logic x, input logic y,
                                                   input logic ci, input logic e);
        if (e) begin
            return {(x & y) | (x & ci) | (y & ci), x ^ y ^ ci};
        end
        return {x & (y | ci), (x ^ y) | ci};
    endfunction

    function automatic logic [XLEN-1:0] add_model(input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b, input logic cin,
                                                  input accuracy_pkg::accuracy_csr_t acc);
        logic [XLEN-1:0] s;
        logic [XLEN-1:0] er;
        logic [3:0]      s4;
        logic            c;
        logic            bc;
        logic            ovf;
        // Accurate mode is plain modular addition
        if (!acc.approximate) begin
            return a + b + {{(XLEN-1){1'b0}}, cin};
        end
        // Positions above APX_LEN are always exact
        er = '1;
        er[APX_LEN-1:0] = acc.error_control[APX_LEN-1:0];
        c = cin;
        for (int k = 0; k < 4; k++) begin
            {c, s[k]} = config_full_add(a[k], b[k], c, er[k]);
        end
        // Upper blocks sum with zero carry-in then increment on carry
        for (int n = 4; n < XLEN; n += 4) begin
            s4[0] = a[n] ^ b[n];
            bc    = a[n] & b[n];
            for (int j = 1; j < 4; j++) begin
                {bc, s4[j]} = config_full_add(a[n+j], b[n+j], bc, er[n+j]);
            end
            ovf = 1'b0;
            if (c) begin
                {ovf, s4} = {1'b0, s4} + 5'd1;
            end
            c = bc | ovf;
            s[n +: 4] = s4;
        end
        return s;
    endfunction

    function automatic logic [XLEN-1:0] ref_alu(input isa_pkg::instr_ctrl_t c,
                                                input accuracy_pkg::accuracy_csr_t acc,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b,
                                                input logic [XLEN-1:0] i);
        logic            r_type;
        logic [XLEN-1:0] op2;
        logic [4:0]      sh;
        logic [XLEN-1:0] res;
        r_type = (c.opcode == isa_pkg::opcode_op);
        op2    = r_type ? b : i;
        sh     = op2[4:0];
        res    = '0;
        if (r_type || c.opcode == isa_pkg::opcode_op_imm) begin
            case (c.funct3)
                isa_pkg::f3_add: begin
                    // Funct7 picks SUB only in the R-type form
                    if (!r_type || c.funct7 == isa_pkg::f7_base) begin
                        res = add_model(a, op2, 1'b0, acc);
                    end else if (c.funct7 == isa_pkg::f7_alt) begin
                        res = add_model(a, ~op2, 1'b1, acc);
                    end
                end
                isa_pkg::f3_sll:  res = a << sh;
                isa_pkg::f3_slt:  res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(op2)};
                isa_pkg::f3_sltu: res = {{(XLEN-1){1'b0}}, a < op2};
                isa_pkg::f3_xor:  res = a ^ op2;
                isa_pkg::f3_sr: begin
                    if (c.funct7 == isa_pkg::f7_base) begin
                        res = a >> sh;
                    end else if (c.funct7 == isa_pkg::f7_alt) begin
                        res = $signed(a) >>> sh;
                    end
                end
                isa_pkg::f3_or:   res = a | op2;
                isa_pkg::f3_and:  res = a & op2;
                default:          res = '0;
            endcase
        end
        return res;
    endfunction

    // ----------------------------------------
    // Checking
    // ----------------------------------------
    task automatic check(input logic [XLEN-1:0] actual, input logic [XLEN-1:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("ERROR at time %0t: %s, got %h, expected %h", $time, what, actual,
                     expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "Check failed");
        end
    endtask

    always @(posedge clk) begin
        issue_seen <= issue;
    end

    // Outputs change only at the rising edge
    always @(negedge clk) begin
        if (arst_n) begin
            check({{(XLEN-1){1'b0}}, result_valid}, {{(XLEN-1){1'b0}}, issue_seen},
                  "result_valid does not follow issue");
            if (issue_seen) begin
                if (expected_q.size() == 0) begin
                    $display("A result arrived with no operation in flight");
                    $display("TESTBENCH FAILED");
                    $fatal(1, "Unexpected result");
                end else begin
                    check(result, expected_q.pop_front(), "wrong result");
                    n_checked++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("The run did not finish within %0d cycles", max_cycles);
            $display("TESTBENCH FAILED");
            $fatal(1, "Timeout");
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic issue_op(input logic [6:0] opcode, input logic [2:0] funct3,
                            input logic [6:0] funct7, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input logic [XLEN-1:0] i);
        issue       = 1'b1;
        ctrl.opcode = opcode;
        ctrl.funct3 = funct3;
        ctrl.funct7 = funct7;
        rs1         = a;
        rs2         = b;
        imm         = i;
        expected_q.push_back(ref_alu(ctrl, accuracy, a, b, i));
        @(posedge clk);
        #drive_delay;
    endtask

    // Operand 2 goes to rs2 or imm, the unused input gets noise
    task automatic issue_sel(input logic use_imm, input logic [2:0] funct3,
                             input logic [6:0] funct7, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b);
        logic [XLEN-1:0] other;
        other = $random(seed);
        if (use_imm) begin
            issue_op(isa_pkg::opcode_op_imm, funct3, funct7, a, other, b);
        end else begin
            issue_op(isa_pkg::opcode_op, funct3, funct7, a, b, other);
        end
    endtask

    task automatic idle_cycle();
        issue = 1'b0;
        @(posedge clk);
        #drive_delay;
    endtask

    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [31:0]     word;
        issue    = 1'b0;
        ctrl     = '0;
        accuracy = '0;
        rs1      = '0;
        rs2      = '0;
        imm      = '0;
        arst_n   = 1'b0;
        repeat (8) @(posedge clk);
        #drive_delay;
        arst_n = 1'b1;

        // Idle outputs after reset
        repeat (2) @(posedge clk);
        #drive_delay;
        check(result, '0, "result not zero after reset");
        check({{(XLEN-1){1'b0}}, result_valid}, '0, "result_valid high before any issue");

        // Logic ops and compares, with equal and sign-boundary operands
        for (int n = 0; n < n_logic; n++) begin
            a = $random(seed);
            b = $random(seed);
            if (n % 8 == 0) begin
                b = a;
            end else if (n % 8 == 1) begin
                a = 32'h8000_0000;
                b = 32'h7fff_ffff;
            end else if (n % 8 == 2) begin
                a = 32'h7fff_ffff;
                b = 32'h8000_0000;
            end
            issue_sel(n[3], logic_f3[n % 5], isa_pkg::f7_base, a, b);
            if (n % 4 == 3) begin
                idle_cycle();
            end
        end

        // Shifts, half of them on negative values
        for (int n = 0; n < n_shift; n++) begin
            a = $random(seed);
            b = $random(seed);
            if (n % 2 == 0) begin
                a[XLEN-1] = 1'b1;
            end
            case (n % 3)
                0:       issue_sel(n[2], isa_pkg::f3_sll, isa_pkg::f7_base, a, b);
                1:       issue_sel(n[2], isa_pkg::f3_sr, isa_pkg::f7_base, a, b);
                default: issue_sel(n[2], isa_pkg::f3_sr, isa_pkg::f7_alt, a, b);
            endcase
        end

        // ADD, SUB and ADDI back to back in accurate mode, then in approximate mode
        for (int n = 0; n < n_add + n_approx; n++) begin
            accuracy             = $random(seed);
            accuracy.approximate = (n >= n_add);
            a = $random(seed);
            b = $random(seed);
            issue_sel(n % 3 == 2, isa_pkg::f3_add,
                      (n % 3 == 1) ? isa_pkg::f7_alt : isa_pkg::f7_base, a, b);
        end

        // Unsupported opcodes and illegal funct7 values
        for (int n = 0; n < n_bad; n++) begin
            word = $random(seed);
            a    = $random(seed);
            b    = $random(seed);
            if (word[6:0] == isa_pkg::opcode_op || word[6:0] == isa_pkg::opcode_op_imm) begin
                word[6] = ~word[6];
            end
            case (n % 4)
                0, 1:    issue_op(word[6:0], word[9:7], word[16:10], a, b, b);
                2:       issue_sel(1'b0, isa_pkg::f3_add, 7'b0000001, a, b);
                default: issue_sel(n[2], isa_pkg::f3_sr, 7'b0100001, a, b);
            endcase
        end

        // Let the last results drain
        idle_cycle();
        idle_cycle();
        if (n_checked != n_issues || expected_q.size() != 0) begin
            $display("Only %0d of %0d issued operations produced a result", n_checked,
                     n_issues);
            $display("TESTBENCH FAILED");
            $fatal(1, "Missing results");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* rv_alu_assert.sv */
// Concurrent checks on the output handshake of the ALU.
// Bound to every rv_alu instance.
`default_nettype none

module rv_alu_assert #(
    parameter int XLEN = 32
) (
    input logic            clk,
    input logic            arst_n,
    input logic            issue,
    input logic [XLEN-1:0] result,
    input logic            result_valid
);

    // Valid stays low while reset is held
    a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !result_valid)
        else $error("result_valid high during reset");

    // One result pulse per issue, one cycle later
    a_valid_after_issue: assert property (@(posedge clk) disable iff (!arst_n)
        issue |=> result_valid)
        else $error("issue not followed by result_valid");

    a_no_extra_valid: assert property (@(posedge clk) disable iff (!arst_n)
        !issue |=> !result_valid)
        else $error("result_valid without a preceding issue");

    // Registered result is fully known when presented
    a_result_known: assert property (@(posedge clk) disable iff (!arst_n)
        result_valid |-> !$isunknown(result))
        else $error("result has unknown bits while valid");

endmodule

bind rv_alu rv_alu_assert #(
    .XLEN (XLEN)
) rv_alu_assert_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .issue        (issue),
    .result       (result),
    .result_valid (result_valid)
);

`default_nettype wire

/* rv_alu.sv */
// Registered RV32I integer ALU for the OP and OP_IMM groups.
// An issue strobe samples the inputs; the result appears one cycle later
// together with a single-cycle result_valid pulse.
`default_nettype none

module rv_alu #(
    parameter int XLEN    = 32,
    parameter int APX_LEN = 8
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         issue,
    input  isa_pkg::instr_ctrl_t         ctrl,
    input  accuracy_pkg::accuracy_csr_t  accuracy,
    input  logic [XLEN-1:0]              rs1,
    input  logic [XLEN-1:0]              rs2,
    input  logic [XLEN-1:0]              imm,
    output logic [XLEN-1:0]              result,
    output logic                         result_valid
);

    localparam int shamt_w = $clog2(XLEN);

    isa_pkg::alu_ctrl_t alu_ctrl;
    logic [XLEN-1:0]    operand_2;
    logic [XLEN-1:0]    adder_b;
    logic [XLEN-1:0]    add_sum;
    logic [XLEN-1:0]    shift_out;
    logic [XLEN-1:0]    alu_result;
    logic               lt_signed;
    logic               lt_unsigned;

    alu_decoder u_decoder (
        .ctrl     (ctrl),
        .alu_ctrl (alu_ctrl)
    );

    // ----------------------------------------
    // Operand preparation
    // ----------------------------------------
    assign operand_2 = alu_ctrl.use_imm ? imm : rs2;

    // SUB is rs1 + ~rs2 + 1
    assign adder_b = alu_ctrl.subtract ? ~operand_2 : operand_2;

    approx_adder #(
        .XLEN    (XLEN),
        .APX_LEN (APX_LEN)
    ) u_adder (
        .a        (rs1),
        .b        (adder_b),
        .carry_in (alu_ctrl.subtract),
        .accuracy (accuracy),
        .sum      (add_sum)
    );

    barrel_shifter #(
        .XLEN (XLEN)
    ) u_shifter (
        .value       (rs1),
        .amount      (operand_2[shamt_w-1:0]),
        .shift_right (alu_ctrl.shift_right),
        .shift_arith (alu_ctrl.shift_arith),
        .shifted     (shift_out)
    );

    // Compares for SLT(I) and SLTU(I)
    assign lt_signed   = $signed(rs1) < $signed(operand_2);
    assign lt_unsigned = rs1 < operand_2;

    // ----------------------------------------
    // Result select
    // ----------------------------------------
    always_comb begin
        case (alu_ctrl.op)
            isa_pkg::alu_add:   alu_result = add_sum;
            isa_pkg::alu_shift: alu_result = shift_out;
            isa_pkg::alu_slt:   alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            isa_pkg::alu_sltu:  alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            isa_pkg::alu_xor:   alu_result = rs1 ^ operand_2;
            isa_pkg::alu_or:    alu_result = rs1 | operand_2;
            isa_pkg::alu_and:   alu_result = rs1 & operand_2;
            // Unsupported encodings
            default:            alu_result = '0;
        endcase
    end

    // Output register, result holds between issues
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue;
            if (issue) begin
                result <= alu_result;
            end
        end
    end

endmodule

`default_nettype wire

/* approx_adder.sv */
// Accuracy-controllable XLEN-bit adder used for ADD, ADDI and SUB.
// The low APX_LEN bits follow the error vector from the accuracy CSR;
// in accurate mode the vector is all ones and the sum is exact.
`default_nettype none

module approx_adder #(
    parameter int XLEN    = 32,
    parameter int APX_LEN = 8
) (
    input  logic [XLEN-1:0]              a,
    input  logic [XLEN-1:0]              b,
    input  logic                         carry_in,
    input  accuracy_pkg::accuracy_csr_t  accuracy,
    output logic [XLEN-1:0]              sum
);

    localparam int bw       = accuracy_pkg::block_width;
    localparam int n_blocks = XLEN / bw;

    // Error vector, bit 0 belongs to sum bit 0
    logic [APX_LEN-1:0]  er_vec;
    // Ripple carries of the low nibble
    logic [bw:0]         low_c;
    // block_carry[n] is the carry out of block n
    logic [n_blocks-1:0] block_carry;

    // Accurate mode forces every position exact
    assign er_vec = accuracy.error_control[APX_LEN-1:0] | {APX_LEN{~accuracy.approximate}};

    // ----------------------------------------
    // Low nibble
    // ----------------------------------------
    // Plain error-configurable ripple, carry_in enters at bit 0
    assign low_c[0] = carry_in;

    for (genvar i = 0; i < bw; i++) begin : g_low
        assign sum[i]     = ~(er_vec[i] & (a[i] ^ b[i]) & low_c[i]) &
                            ((a[i] ^ b[i]) | low_c[i]);
        assign low_c[i+1] = (er_vec[i] & b[i] & low_c[i]) |
                            ((b[i] | low_c[i]) & a[i]);
    end

    assign block_carry[0] = low_c[bw];

    // ----------------------------------------
    // Carry-select blocks above the low nibble
    // ----------------------------------------
    for (genvar n = 1; n < n_blocks; n++) begin : g_block
        // Blocks below APX_LEN are approximate
        localparam bit blk_approx = (n * bw) < APX_LEN;

        logic [bw-2:0] blk_er;

        if (blk_approx) begin : g_er_apx
            // Slice bit 0 is a half adder and takes no error bit
            assign blk_er = er_vec[n*bw+bw-1 : n*bw+1];
        end else begin : g_er_exact
            assign blk_er = '1;
        end

        carry_select_block #(
            .APPROX (blk_approx)
        ) u_block (
            .a         (a[n*bw +: bw]),
            .b         (b[n*bw +: bw]),
            .er        (blk_er),
            .carry_in  (block_carry[n-1]),
            .sum       (sum[n*bw +: bw]),
            .carry_out (block_carry[n])
        );
    end

endmodule

`default_nettype wire

/* carry_select_block.sv */
// One 4-bit slice of the carry-select adder.
// The slice sums with zero carry-in, then an increment unit applies the real carry.
// APPROX selects error-configurable full adders for bits 1 to 3.
`default_nettype none

module carry_select_block #(
    parameter bit APPROX = 1'b1
) (
    input  logic [accuracy_pkg::block_width-1:0] a,
    input  logic [accuracy_pkg::block_width-1:0] b,
    // Error bits for slice bits 1 to 3, 1 means exact
    input  logic [accuracy_pkg::block_width-2:0] er,
    input  logic                                 carry_in,
    output logic [accuracy_pkg::block_width-1:0] sum,
    output logic                                 carry_out
);

    localparam int bw = accuracy_pkg::block_width;

    logic [bw-2:0] er_eff;
    // ripple[i] is the carry into bit i
    logic [bw:1]   ripple;
    logic [bw-1:0] plain_sum;
    logic [bw-1:0] inc_sum;
    logic          inc_ovf;

    // Exact slice behaves as if every error bit were set
    assign er_eff = APPROX ? er : '1;

    // ----------------------------------------
    // Zero carry-in sum
    // ----------------------------------------
    // Bit 0 is a half adder
    assign plain_sum[0] = a[0] ^ b[0];
    assign ripple[1]    = a[0] & b[0];

    // Error-configurable full adders
    // er 1 gives the exact sum and carry
    // er 0 gives sum (a^b)|cin and carry a&(b|cin)
    for (genvar i = 1; i < bw; i++) begin : g_fa
        assign plain_sum[i] = ~(er_eff[i-1] & (a[i] ^ b[i]) & ripple[i]) &
                              ((a[i] ^ b[i]) | ripple[i]);
        assign ripple[i+1]  = (er_eff[i-1] & b[i] & ripple[i]) |
                              ((b[i] | ripple[i]) & a[i]);
    end

    // ----------------------------------------
    // Increment unit and carry select
    // ----------------------------------------
    assign {inc_ovf, inc_sum} = {1'b0, plain_sum} + 1'b1;

    assign sum       = carry_in ? inc_sum : plain_sum;
    // Overflow of the increment only counts when it was selected
    assign carry_out = ripple[bw] | (carry_in & inc_ovf);

endmodule

`default_nettype wire

/* barrel_shifter.sv */
// Logarithmic barrel shifter for SLL, SRL and SRA.
// Left shifts are done as right shifts on the bit-reversed operand.
`default_nettype none

module barrel_shifter #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0]          value,
    input  logic [$clog2(XLEN)-1:0]  amount,
    input  logic                     shift_right,
    input  logic                     shift_arith,
    output logic [XLEN-1:0]          shifted
);

    localparam int shamt_w = $clog2(XLEN);

    // Stage 0 is the (possibly reversed) input, stage shamt_w the shifted word
    logic [shamt_w:0][XLEN-1:0] stage;
    logic [XLEN-1:0]            value_rev;
    logic [XLEN-1:0]            stage_rev;
    // Bit shifted in from the top
    logic                       fill;

    // Sign fill only for arithmetic right shifts
    assign fill = shift_right & shift_arith & value[XLEN-1];

    // ----------------------------------------
    // Bit reversal around the shift stages
    // ----------------------------------------
    for (genvar i = 0; i < XLEN; i++) begin : g_rev
        assign value_rev[i] = value[XLEN-1-i];
        assign stage_rev[i] = stage[shamt_w][XLEN-1-i];
    end

    assign stage[0] = shift_right ? value : value_rev;

    // Stage k shifts by 2**k when amount bit k is set
    for (genvar k = 0; k < shamt_w; k++) begin : g_stage
        assign stage[k+1] = amount[k] ?
                            {{(2**k){fill}}, stage[k][XLEN-1:2**k]} :
                            stage[k];
    end

    // Undo the reversal for left shifts
    assign shifted = shift_right ? stage[shamt_w] : stage_rev;

endmodule

`default_nettype wire

/* alu_decoder.sv */
// Translates opcode, funct3 and funct7 into ALU control fields.
// Purely combinational; unsupported encodings map to the none class.
`default_nettype none

module alu_decoder (
    input  isa_pkg::instr_ctrl_t ctrl,
    output isa_pkg::alu_ctrl_t   alu_ctrl
);

    logic is_op;
    logic is_op_imm;
    // Funct7 is one of the two legal values
    logic f7_known;
    logic f7_is_alt;

    assign is_op     = (ctrl.opcode == isa_pkg::opcode_op);
    assign is_op_imm = (ctrl.opcode == isa_pkg::opcode_op_imm);
    assign f7_is_alt = (ctrl.funct7 == isa_pkg::f7_alt);
    assign f7_known  = (ctrl.funct7 == isa_pkg::f7_base) || f7_is_alt;

    always_comb begin
        // Default is class none with all modifiers low
        alu_ctrl             = '0;
        alu_ctrl.op          = isa_pkg::alu_none;

        if (is_op || is_op_imm) begin
            // I-type takes operand 2 from the immediate
            alu_ctrl.use_imm = is_op_imm;

            case (ctrl.funct3)
                isa_pkg::f3_add: begin
                    // ADDI ignores funct7, it is part of the immediate
                    if (is_op_imm) begin
                        alu_ctrl.op = isa_pkg::alu_add;
                    end else if (f7_known) begin
                        alu_ctrl.op       = isa_pkg::alu_add;
                        alu_ctrl.subtract = f7_is_alt;
                    end
                end
                isa_pkg::f3_sll: begin
                    alu_ctrl.op = isa_pkg::alu_shift;
                end
                isa_pkg::f3_slt: begin
                    alu_ctrl.op = isa_pkg::alu_slt;
                end
                isa_pkg::f3_sltu: begin
                    alu_ctrl.op = isa_pkg::alu_sltu;
                end
                isa_pkg::f3_xor: begin
                    alu_ctrl.op = isa_pkg::alu_xor;
                end
                isa_pkg::f3_sr: begin
                    // SRL/SRA and SRLI/SRAI both need a legal funct7
                    if (f7_known) begin
                        alu_ctrl.op          = isa_pkg::alu_shift;
                        alu_ctrl.shift_right = 1'b1;
                        alu_ctrl.shift_arith = f7_is_alt;
                    end
                end
                isa_pkg::f3_or: begin
                    alu_ctrl.op = isa_pkg::alu_or;
                end
                isa_pkg::f3_and: begin
                    alu_ctrl.op = isa_pkg::alu_and;
                end
                default: begin
                    alu_ctrl.op = isa_pkg::alu_none;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* accuracy_pkg.sv */
// Layout of the accuracy control CSR that tunes the approximate adder,
// and the block size the adder is built from.
`default_nettype none

package accuracy_pkg;

    // Adder block size in bits
    localparam int block_width = 4;

    // Accuracy CSR
    // Only the low APX_LEN error_control bits have meaning
    // circuit_select is carried but there is a single adder
    typedef struct packed {
        logic [28:0] error_control;
        logic [1:0]  circuit_select;
        // 1 selects approximate mode, 0 forces exact addition
        logic        approximate;
    } accuracy_csr_t;

endpackage

`default_nettype wire

/* isa_pkg.sv */
// RV32I instruction field codes for the integer ALU, and the decoded control word.
// The decoder and the ALU top level refer to these by scoped names.
`default_nettype none

package isa_pkg;

    // Supported major opcodes
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;

    // Funct3 codes, identical for R-type and I-type
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    // Shift right, logical or arithmetic by funct7
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // Funct7: base selects ADD and logical shift, alt selects SUB and arithmetic shift
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    // Raw instruction fields as delivered by the instruction decoder
    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
    } instr_ctrl_t;

    // Result class chosen by the output mux
    typedef enum logic [2:0] {
        alu_none,
        alu_add,
        alu_shift,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and
    } alu_op_e;

    // Decoded ALU control
    typedef struct packed {
        alu_op_e op;
        logic    use_imm;
        logic    subtract;
        logic    shift_right;
        logic    shift_arith;
    } alu_ctrl_t;

endpackage

`default_nettype wire
